// ==== src/fw_bus_pkg.sv ====
/*
 * Firmware memory subsystem bus definitions.
 * Data and strobe widths of the APB side and the phase encoding
 * used by the slave port FSM.
 */

package fw_bus_pkg;

  // --------------------------------------------------------------------------
  // Data path widths
  // --------------------------------------------------------------------------

  // APB data bus, one 32-bit word per transfer
  localparam int DATA_W = 32;

  // One write strobe per byte lane
  localparam int STRB_W = DATA_W / 8;

  // --------------------------------------------------------------------------
  // APB slave phases
  // --------------------------------------------------------------------------

  // Idle     no transfer, waiting for a setup cycle
  // Access   setup seen, request goes out on the first penable cycle
  // Respond  request issued, waiting for the registered response
  typedef enum logic [1:0] {
    APB_IDLE    = 2'd0,
    APB_ACCESS  = 2'd1,
    APB_RESPOND = 2'd2
  } apb_state_e;

endpackage

// ==== src/fw_mem_pkg.sv ====
/*
 * Firmware memory subsystem memory map.
 * Address width, window bases, control register offsets, the value
 * returned on refused accesses and the region decode encoding.
 */

package fw_mem_pkg;

  // --------------------------------------------------------------------------
  // Address space
  // --------------------------------------------------------------------------

  // Byte address width on paddr, 4 KiB of space
  localparam int ADDR_W = 12;

  // Firmware RAM window, sized by RAM_DEPTH at the top level
  localparam logic [ADDR_W-1:0] RAM_BASE = 12'h000;

  // Control window, upper half of the space
  localparam logic [ADDR_W-1:0] CTRL_BASE = 12'h800;

  // --------------------------------------------------------------------------
  // Control registers, as word offsets from CTRL_BASE
  // --------------------------------------------------------------------------

  // Mode register, bit 0 sets application mode (sticky)
  localparam logic [ADDR_W-3:0] CTRL_MODE_OFS = '0;

  // Status register, bit 0 app mode, bit 1 denial seen
  localparam logic [ADDR_W-3:0] CTRL_STATUS_OFS = 10'd1;

  // --------------------------------------------------------------------------
  // Responses
  // --------------------------------------------------------------------------

  // Read value for denied or unmapped accesses, full 32-bit bus word
  localparam logic [31:0] DENY_DATA = 32'h0000_0000;

  // Target of a decoded request
  typedef enum logic [1:0] {
    REGION_RAM  = 2'd0,
    REGION_CTRL = 2'd1,
    REGION_NONE = 2'd2
  } region_e;

endpackage

// ==== src/apb_slave_port.sv ====
/*
 * APB slave port.
 * Follows the setup and access phases of each transfer and turns it
 * into exactly one internal request pulse, then holds off until the
 * response for that request has been returned.
 */

`timescale 1ns/1ps

module apb_slave_port
  import fw_bus_pkg::*, fw_mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,

  // APB slave side
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  input  logic [STRB_W-1:0] pstrb,

  // Response returned for the request in flight
  input  logic              rsp_valid,

  // Internal request
  output logic              req_valid,
  output logic              req_write,
  output logic [ADDR_W-1:0] req_addr,
  output logic [DATA_W-1:0] req_wdata,
  output logic [STRB_W-1:0] req_strb
);

  // --------------------------------------------------------------------------
  // Phase tracking
  // --------------------------------------------------------------------------

  apb_state_e state;
  apb_state_e state_next;

  // Setup cycle of a new transfer
  logic setup_seen;

  // First access cycle of the transfer being tracked
  logic access_seen;

  assign setup_seen  = psel && !penable;
  assign access_seen = (state == APB_ACCESS) && psel && penable;

  always_comb begin
    state_next = state;
    unique case (state)
      APB_IDLE: begin
        if (setup_seen) begin
          state_next = APB_ACCESS;
        end
      end
      APB_ACCESS: begin
        // Request goes out here, then wait for its response
        if (access_seen) begin
          state_next = APB_RESPOND;
        end else if (!psel) begin
          // Master dropped the transfer after setup
          state_next = APB_IDLE;
        end
      end
      APB_RESPOND: begin
        // penable still high here, no second request
        if (rsp_valid) begin
          state_next = APB_IDLE;
        end
      end
      default: begin
        state_next = APB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= APB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------------------------------
  // Request outputs
  // --------------------------------------------------------------------------

  // One pulse, same cycle as the penable rise
  assign req_valid = access_seen;

  // Master holds these stable for the whole transfer
  assign req_write = pwrite;
  assign req_addr  = paddr;
  assign req_wdata = pwdata;

  // Reads never carry strobes
  assign req_strb  = pwrite ? pstrb : '0;

endmodule

// ==== src/fw_access_ctrl.sv ====
/*
 * Firmware access control.
 * Decodes each request into RAM, control or unmapped, holds the sticky
 * application-mode flag and lets RAM traffic through only while the
 * flag is clear. Produces a registered response one cycle later.
 */

`timescale 1ns/1ps

module fw_access_ctrl
  import fw_bus_pkg::*, fw_mem_pkg::*;
#(
  parameter int RAM_DEPTH = 512
) (
  input  logic                         clk,
  input  logic                         reset_n,

  // Request from the slave port
  input  logic                         req_valid,
  input  logic                         req_write,
  input  logic [ADDR_W-1:0]            req_addr,
  input  logic [DATA_W-1:0]            req_wdata,
  input  logic [STRB_W-1:0]            req_strb,

  // RAM side
  output logic                         ram_cs,
  output logic [STRB_W-1:0]            ram_we,
  output logic [$clog2(RAM_DEPTH)-1:0] ram_addr,
  output logic [DATA_W-1:0]            ram_wdata,

  // Response to the output mux
  output logic                         rsp_valid,
  output logic                         rsp_error,
  output logic                         rsp_sel_ram,
  output logic [DATA_W-1:0]            rsp_ctrl_data
);

  localparam int RAM_AW = $clog2(RAM_DEPTH);

  // --------------------------------------------------------------------------
  // Region decode
  // --------------------------------------------------------------------------

  region_e           region;
  logic [ADDR_W-1:0] ram_ofs;
  logic [ADDR_W-1:0] ctrl_ofs;
  logic              is_mode;
  logic              is_status;

  assign ram_ofs  = req_addr - RAM_BASE;
  assign ctrl_ofs = req_addr - CTRL_BASE;

  // Word offsets inside the control window
  assign is_mode   = (req_addr >= CTRL_BASE) && (ctrl_ofs[ADDR_W-1:2] == CTRL_MODE_OFS);
  assign is_status = (req_addr >= CTRL_BASE) && (ctrl_ofs[ADDR_W-1:2] == CTRL_STATUS_OFS);

  // Control registers win over the RAM window if the two overlap
  always_comb begin
    if (is_mode || is_status) begin
      region = REGION_CTRL;
    end else if ((req_addr >= RAM_BASE) && (int'(ram_ofs) < RAM_DEPTH * 4)) begin
      region = REGION_RAM;
    end else begin
      region = REGION_NONE;
    end
  end

  // --------------------------------------------------------------------------
  // Mode and denial state
  // --------------------------------------------------------------------------

  logic app_mode;
  logic denied;
  logic deny;
  logic set_app;

  // RAM request refused once in application mode
  assign deny = req_valid && (region == REGION_RAM) && app_mode;

  // Mode register write with bit 0 set in an enabled byte 0
  assign set_app = req_valid && req_write && is_mode && req_strb[0] && req_wdata[0];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode <= 1'b0;
      denied   <= 1'b0;
    end else begin
      // Both flags stay set until the next reset
      if (set_app) begin
        app_mode <= 1'b1;
      end
      if (deny) begin
        denied <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // RAM request in the same cycle as req_valid
  // --------------------------------------------------------------------------

  assign ram_cs    = req_valid && (region == REGION_RAM) && !app_mode;
  assign ram_we    = {STRB_W{ram_cs && req_write}} & req_strb;
  assign ram_addr  = ram_ofs[RAM_AW+1:2];
  assign ram_wdata = req_wdata;

  // --------------------------------------------------------------------------
  // Registered response
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rsp_valid   <= 1'b0;
      rsp_error   <= 1'b0;
      rsp_sel_ram <= 1'b0;
    end else begin
      rsp_valid   <= req_valid;
      rsp_error   <= deny || (req_valid && (region == REGION_NONE));
      rsp_sel_ram <= req_valid && (region == REGION_RAM);
    end
  end

  // Status word shared by both offsets
  always_ff @(posedge clk) begin
    if (req_valid) begin
      rsp_ctrl_data <= {{(DATA_W-2){1'b0}}, denied, app_mode};
    end
  end

endmodule

// ==== src/fw_ram.sv ====
/*
 * Firmware RAM.
 * Behavioral RAM_DEPTH x 32 array with per-byte write enables and a
 * registered read. ready marks the cycle the read data is valid.
 */

`timescale 1ns/1ps

module fw_ram
  import fw_bus_pkg::*;
#(
  parameter int RAM_DEPTH = 512
) (
  input  logic                         clk,
  input  logic                         reset_n,

  input  logic                         cs,
  input  logic [STRB_W-1:0]            we,
  input  logic [$clog2(RAM_DEPTH)-1:0] address,
  input  logic [DATA_W-1:0]            write_data,
  output logic [DATA_W-1:0]            read_data,
  output logic                         ready
);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  logic [DATA_W-1:0] mem [RAM_DEPTH];

  // Byte lane writes, only the strobed lanes change
  always_ff @(posedge clk) begin
    if (cs) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (we[b]) begin
          mem[address][b*8 +: 8] <= write_data[b*8 +: 8];
        end
      end
    end
  end

  // Registered read, old word on a write cycle
  always_ff @(posedge clk) begin
    if (cs) begin
      read_data <= mem[address];
    end
  end

  // --------------------------------------------------------------------------
  // Ready, one cycle behind cs
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
    end else begin
      ready <= cs;
    end
  end

endmodule

// ==== src/apb_resp_mux.sv ====
/*
 * APB response mux.
 * Picks the read data for the finishing transfer and drives pready
 * and pslverr straight from the registered response.
 */

`timescale 1ns/1ps

module apb_resp_mux
  import fw_bus_pkg::*, fw_mem_pkg::*;
(
  // Registered response from access control
  input  logic              rsp_valid,
  input  logic              rsp_error,
  input  logic              rsp_sel_ram,
  input  logic [DATA_W-1:0] rsp_ctrl_data,

  // Read word from the RAM, valid with rsp_valid
  input  logic [DATA_W-1:0] ram_rdata,

  // APB response
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  // --------------------------------------------------------------------------
  // Read data select
  // --------------------------------------------------------------------------

  always_comb begin
    if (rsp_error) begin
      // Nothing leaks on a refused access
      prdata = DENY_DATA;
    end else if (rsp_sel_ram) begin
      prdata = ram_rdata;
    end else begin
      // Control window read
      prdata = rsp_ctrl_data;
    end
  end

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Single wait state, ends the cycle the response lands
  assign pready  = rsp_valid;

  // Error only alongside pready
  assign pslverr = rsp_valid && rsp_error;

endmodule

// ==== src/fw_mem_subsys.sv ====
/*
 * Firmware memory subsystem top level.
 * APB slave port, access control, firmware RAM and response mux,
 * with RAM_DEPTH passed down to the blocks that size by it.
 */

`timescale 1ns/1ps

module fw_mem_subsys
  import fw_bus_pkg::*, fw_mem_pkg::*;
#(
  parameter int RAM_DEPTH = 512
) (
  input  logic              clk,
  input  logic              reset_n,

  // APB slave
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  input  logic [STRB_W-1:0] pstrb,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  localparam int RAM_AW = $clog2(RAM_DEPTH);

  // --------------------------------------------------------------------------
  // Internal wiring
  // --------------------------------------------------------------------------

  // Request, port to access control
  logic              req_valid;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic [STRB_W-1:0] req_strb;

  // RAM port
  logic              ram_cs;
  logic [STRB_W-1:0] ram_we;
  logic [RAM_AW-1:0] ram_addr;
  logic [DATA_W-1:0] ram_wdata;
  logic [DATA_W-1:0] ram_rdata;

  // Response, access control to mux
  logic              rsp_valid;
  logic              rsp_error;
  logic              rsp_sel_ram;
  logic [DATA_W-1:0] rsp_ctrl_data;

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------

  apb_slave_port u_port (
    .clk       (clk),
    .reset_n   (reset_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .rsp_valid (rsp_valid),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_strb  (req_strb)
  );

  fw_access_ctrl #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_strb      (req_strb),
    .ram_cs        (ram_cs),
    .ram_we        (ram_we),
    .ram_addr      (ram_addr),
    .ram_wdata     (ram_wdata),
    .rsp_valid     (rsp_valid),
    .rsp_error     (rsp_error),
    .rsp_sel_ram   (rsp_sel_ram),
    .rsp_ctrl_data (rsp_ctrl_data)
  );

  // ready unused here, rsp_valid marks the same cycle
  fw_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_ram (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (ram_cs),
    .we         (ram_we),
    .address    (ram_addr),
    .write_data (ram_wdata),
    .read_data  (ram_rdata),
    .ready      ()
  );

  apb_resp_mux u_rsp (
    .rsp_valid     (rsp_valid),
    .rsp_error     (rsp_error),
    .rsp_sel_ram   (rsp_sel_ram),
    .rsp_ctrl_data (rsp_ctrl_data),
    .ram_rdata     (ram_rdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr)
  );

endmodule

// ==== test/tb_fw_mem_subsys.sv ====
/*
 * Testbench for the firmware memory subsystem.
 * Drives APB transfers, tracks RAM contents and the mode flags in a
 * reference model, and checks data and handshake timing.
 */

`timescale 1ns/1ps

module tb_fw_mem_subsys
  import fw_bus_pkg::*, fw_mem_pkg::*;
();

  localparam int RAM_DEPTH    = 512;
  localparam int RESET_CYCLES = 5;
  localparam int READY_WAIT   = 8;

  // Transfers issued by each test
  localparam int T1_WORDS  = 64;
  localparam int T2_WRITES = 32;
  localparam int T3_XFERS  = 7;
  localparam int T4_WORDS  = 8;
  localparam int T5_ADDRS  = 8;
  localparam int T5_RAM    = 4;
  localparam int T6_XFERS  = 32;

  localparam int TOTAL_XFERS = 2 * T1_WORDS + 2 * T2_WRITES + T3_XFERS + 3 * T4_WORDS + 2
                             + 2 * T5_ADDRS + 1 + T5_RAM + T6_XFERS;

  // Three cycles per transfer, rest is slack for idle gaps
  localparam int CYCLE_LIMIT = 6 * TOTAL_XFERS + 2 * RESET_CYCLES;

  localparam logic [ADDR_W-1:0] MODE_ADDR   = CTRL_BASE + {CTRL_MODE_OFS, 2'b00};
  localparam logic [ADDR_W-1:0] STATUS_ADDR = CTRL_BASE + {CTRL_STATUS_OFS, 2'b00};

  logic              clk;
  logic              reset_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic [STRB_W-1:0] pstrb;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  // Reference model
  logic [DATA_W-1:0] model_mem [RAM_DEPTH];
  logic              model_app;
  logic              model_denied;
  int                written[$];

  string cur_test;
  int    test_errors;
  int    tests_passed;
  int    tests_failed;
  int    cycles;

  fw_mem_subsys #(
    .RAM_DEPTH (RAM_DEPTH)
  ) dut (
    .clk     (clk),
    .reset_n (reset_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hard stop for a hung handshake
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after reaching the limit of %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic note_failure();
    test_errors++;
  endtask

  // --------------------------------------------------------------------------
  // Handshake checks
  // --------------------------------------------------------------------------

  // Setup, one wait state, then pready
  a_one_wait_state: assert property (
    @(posedge clk) disable iff (!reset_n)
      (psel && !penable) |=> (!pready ##1 pready)
  ) else begin
    $display("Transfer at %0t did not end exactly two cycles after setup", $time);
    note_failure();
  end

  a_err_with_ready: assert property (
    @(posedge clk) disable iff (!reset_n) pslverr |-> pready
  ) else begin
    $display("pslverr was high without pready at %0t", $time);
    note_failure();
  end

  a_ready_in_access: assert property (
    @(posedge clk) disable iff (!reset_n) pready |-> (psel && penable)
  ) else begin
    $display("pready was high outside an access phase at %0t", $time);
    note_failure();
  end

  // --------------------------------------------------------------------------
  // Model helpers
  // --------------------------------------------------------------------------

  function automatic region_e decode_region(input logic [ADDR_W-1:0] addr);
    int ofs;
    ofs = (int'(addr) - int'(CTRL_BASE)) / 4;
    if ((addr >= CTRL_BASE) && (ofs == int'(CTRL_MODE_OFS) || ofs == int'(CTRL_STATUS_OFS))) begin
      return REGION_CTRL;
    end
    if ((addr >= RAM_BASE) && (int'(addr) - int'(RAM_BASE) < RAM_DEPTH * 4)) begin
      return REGION_RAM;
    end
    return REGION_NONE;
  endfunction

  function automatic int ram_index(input logic [ADDR_W-1:0] addr);
    return (int'(addr) - int'(RAM_BASE)) / 4;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // Bit 0 app mode, bit 1 denial since reset
  function automatic logic [DATA_W-1:0] status_word();
    return {{(DATA_W-2){1'b0}}, model_denied, model_app};
  endfunction

  // Above the control registers, or between RAM and control window
  function automatic logic [ADDR_W-1:0] pick_unmapped_addr();
    int lo_word;
    int hi_word;
    int word;
    lo_word = int'(CTRL_BASE) / 4 + 2;
    hi_word = (1 << ADDR_W) / 4 - 1;
    if ((RAM_DEPTH * 4 < int'(CTRL_BASE)) && ($urandom_range(1, 0) == 1)) begin
      word = $urandom_range(int'(CTRL_BASE) / 4 - 1, RAM_DEPTH);
    end else begin
      word = $urandom_range(hi_word, lo_word);
    end
    return ADDR_W'(word * 4);
  endfunction

  // --------------------------------------------------------------------------
  // APB driver
  // --------------------------------------------------------------------------

  // Entered and left 1 ns after a rising edge
  task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                              output logic [DATA_W-1:0] rdata, output logic err);
    int waited;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = write ? strb : '0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited  = 0;
    while (!pready && (waited < READY_WAIT)) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!pready) begin
      $display("%s: no pready within %0d cycles for address %h", cur_test, READY_WAIT, addr);
      note_failure();
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, output logic err);
    logic [DATA_W-1:0] unused;
    apb_transfer(1'b1, addr, data, strb, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, '0, '0, data, err);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n      = 1'b1;
    model_app    = 1'b0;
    model_denied = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Checked accesses
  // --------------------------------------------------------------------------

  task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected)
    else begin
      $display("error %s %s expected %h actual %h", cur_test, what, expected, actual);
      note_failure();
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    assert (actual === expected)
    else begin
      $display("error %s %s expected %0b actual %0b", cur_test, what, expected, actual);
      note_failure();
    end
  endtask

  task automatic write_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
    region_e region;
    logic    exp_err;
    logic    err;
    int      idx;
    region  = decode_region(addr);
    idx     = ram_index(addr);
    exp_err = (region == REGION_NONE) || ((region == REGION_RAM) && model_app);
    apb_write(addr, data, strb, err);
    check_flag($sformatf("pslverr on write to %h", addr), exp_err, err);
    if (region == REGION_RAM) begin
      if (model_app) begin
        model_denied = 1'b1;
      end else begin
        model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
      end
    end else if ((region == REGION_CTRL) && (addr[ADDR_W-1:2] == MODE_ADDR[ADDR_W-1:2])) begin
      // Sticky, a zero never clears it
      if (strb[0] && data[0]) begin
        model_app = 1'b1;
      end
    end
  endtask

  task automatic read_check(input logic [ADDR_W-1:0] addr);
    region_e           region;
    logic              exp_err;
    logic              err;
    logic [DATA_W-1:0] exp_data;
    logic [DATA_W-1:0] data;
    region  = decode_region(addr);
    exp_err = (region == REGION_NONE) || ((region == REGION_RAM) && model_app);
    if (exp_err) begin
      exp_data = DENY_DATA;
    end else if (region == REGION_RAM) begin
      exp_data = model_mem[ram_index(addr)];
    end else begin
      exp_data = status_word();
    end
    apb_read(addr, data, err);
    check_value($sformatf("read of %h", addr), exp_data, data);
    check_flag($sformatf("pslverr on read of %h", addr), exp_err, err);
    if ((region == REGION_RAM) && model_app) begin
      model_denied = 1'b1;
    end
  endtask

  function automatic logic [ADDR_W-1:0] written_addr(input int n);
    return RAM_BASE + ADDR_W'(written[n] * 4);
  endfunction

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s FAILED with %0d errors", cur_test, test_errors);
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic write_readback_words();
    start_test("full_word");
    for (int i = 0; i < T1_WORDS; i++) begin
      written.push_back($urandom_range(RAM_DEPTH - 1, 0));
      write_check(written_addr(i), $urandom, '1);
    end
    for (int i = 0; i < T1_WORDS; i++) begin
      read_check(written_addr(i));
    end
    finish_test();
  endtask

  // Partial strobes only, never none or all
  task automatic byte_strobe_merge();
    int n;
    start_test("byte_strobe");
    for (int i = 0; i < T2_WRITES; i++) begin
      n = $urandom_range(written.size() - 1, 0);
      write_check(written_addr(n), $urandom, STRB_W'($urandom_range(14, 1)));
      read_check(written_addr(n));
    end
    finish_test();
  endtask

  task automatic mode_register_sticky();
    start_test("mode_register");
    read_check(STATUS_ADDR);
    write_check(MODE_ADDR, 32'h0, '1);
    read_check(STATUS_ADDR);
    write_check(MODE_ADDR, 32'h1, '1);
    read_check(MODE_ADDR);
    write_check(MODE_ADDR, 32'h0, '1);
    read_check(STATUS_ADDR);
    finish_test();
  endtask

  // Entered with app mode set by the mode test
  task automatic app_mode_denial();
    start_test("app_denial");
    for (int i = 0; i < T4_WORDS; i++) begin
      read_check(written_addr(i));
      write_check(written_addr(i), $urandom, '1);
    end
    read_check(STATUS_ADDR);
    apply_reset();
    read_check(STATUS_ADDR);
    // Dropped writes leave the firmware image intact
    for (int i = 0; i < T4_WORDS; i++) begin
      read_check(written_addr(i));
    end
    finish_test();
  endtask

  task automatic unmapped_access();
    logic [ADDR_W-1:0] addr;
    start_test("unmapped");
    for (int i = 0; i < T5_ADDRS; i++) begin
      addr = pick_unmapped_addr();
      write_check(addr, $urandom, '1);
      read_check(addr);
    end
    read_check(STATUS_ADDR);
    for (int i = 0; i < T5_RAM; i++) begin
      read_check(written_addr($urandom_range(written.size() - 1, 0)));
    end
    finish_test();
  endtask

  // First half back to back, second half with idle gaps
  task automatic back_to_back_timing();
    int n;
    start_test("timing");
    for (int i = 0; i < T6_XFERS; i++) begin
      n = $urandom_range(written.size() - 1, 0);
      if (i % 2 == 0) begin
        write_check(written_addr(n), $urandom, '1);
      end else begin
        read_check(written_addr(n));
      end
      if (i >= T6_XFERS / 2) begin
        idle_cycles($urandom_range(2, 1));
      end
    end
    idle_cycles(2);
    finish_test();
  endtask

  initial begin
    reset_n      = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pstrb        = '0;
    cycles       = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(32'h58a));
    apply_reset();

    write_readback_words();
    byte_strobe_merge();
    mode_register_sticky();
    app_mode_denial();
    unmapped_access();
    back_to_back_timing();

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
src/fw_bus_pkg.sv
src/fw_mem_pkg.sv
src/apb_slave_port.sv
src/fw_access_ctrl.sv
src/fw_ram.sv
src/apb_resp_mux.sv
src/fw_mem_subsys.sv
test/tb_fw_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: fw_mem_subsys

sources:
  # Packages first, the RTL blocks import them
  - files:
      - src/fw_bus_pkg.sv
      - src/fw_mem_pkg.sv
      - src/apb_slave_port.sv
      - src/fw_access_ctrl.sv
      - src/fw_ram.sv
      - src/apb_resp_mux.sv
      - src/fw_mem_subsys.sv

  - target: test
    files:
      - test/tb_fw_mem_subsys.sv
